//--- verilog.f
hdl/core_pkg.sv
hdl/decode_if.sv
hdl/fetch_unit.sv
hdl/inst_decoder.sv
hdl/reg_file.sv
hdl/exec_alu.sv
hdl/branch_unit.sv
hdl/writeback_unit.sv
hdl/core_top.sv
verif/tb_clock_gen.sv
verif/core_sva.sv
verif/core_tb.sv

//--- Bender.yml
package:
  name: rv32i_core

sources:
  - hdl/core_pkg.sv
  - hdl/decode_if.sv
  - hdl/fetch_unit.sv
  - hdl/inst_decoder.sv
  - hdl/reg_file.sv
  - hdl/exec_alu.sv
  - hdl/branch_unit.sv
  - hdl/writeback_unit.sv
  - hdl/core_top.sv
  - target: test
    files:
      - verif/tb_clock_gen.sv
      - verif/core_sva.sv
      - verif/core_tb.sv

//--- verif/core_tb.sv
/* directed tests with a stalling instruction memory and a reference model
   programs are placed at the model pc and end where the model pc reaches their end */
`timescale 1ns/1ps
`default_nettype none

module core_tb;

    localparam int MEM_WORDS = 1024;
    localparam int TIMEOUT   = 200;  // cycles per wait loop

    logic        clk;
    logic        reset;
    logic        imem_req;
    logic [31:0] imem_addr;
    logic        imem_valid;
    logic [31:0] imem_rdata;
    logic        retire_valid;
    logic [31:0] retire_pc;
    logic        retire_we;
    logic [4:0]  retire_rd;
    logic [31:0] retire_wdata;
    logic [31:0] retire_next_pc;

    logic [31:0] mem [MEM_WORDS];
    logic [31:0] m_regs [32];
    logic [31:0] m_pc;
    logic [31:0] load_ptr;
    logic [15:0] lfsr;
    logic        stall_mode;
    int          delay_cnt;
    int          errors;
    int          tests;
    int          fetch_count;
    int          retire_count;

    tb_clock_gen i_clk (.clk(clk), .reset(reset));

    core_top i_dut (
        .clk            (clk),
        .reset          (reset),
        .imem_req       (imem_req),
        .imem_addr      (imem_addr),
        .imem_valid     (imem_valid),
        .imem_rdata     (imem_rdata),
        .retire_valid   (retire_valid),
        .retire_pc      (retire_pc),
        .retire_we      (retire_we),
        .retire_rd      (retire_rd),
        .retire_wdata   (retire_wdata),
        .retire_next_pc (retire_next_pc)
    );

    // addi x0, x0, imm with imm folded from every address bit
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        logic [11:0] imm;
        imm = addr[11:0] ^ addr[23:12] ^ {4'b0, addr[31:24]};
        return {imm, 5'd0, 3'b000, 5'd0, 7'h13};
    endfunction

    function automatic logic [31:0] mem_read(input logic [31:0] addr);
        logic [31:0] idx;
        idx = (addr - 32'h8000_0000) >> 2;
        if (idx < MEM_WORDS) begin
            return mem[idx];
        end
        return 32'h0;  // opcode 0, retires as a no-op
    endfunction

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] enc_r(input int f7, input int rs2, input int rs1,
                                          input int f3, input int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
    endfunction

    function automatic logic [31:0] enc_i(input int imm, input int rs1, input int f3,
                                          input int rd, input logic [6:0] op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] enc_b(input int imm, input int rs2, input int rs1,
                                          input int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] enc_j(input int imm, input int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
    endfunction

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'b0, $signed(a) < $signed(b)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    // memory answers each request with one valid pulse after 0 to 7 cycles
    always begin
        @(posedge clk);
        #1;
        if (imem_valid) begin
            imem_valid = 1'b0;
        end else if (imem_req) begin
            if (delay_cnt == 0) begin
                imem_valid = 1'b1;
                imem_rdata = mem_read(imem_addr);
                fetch_count++;
                if (stall_mode) begin
                    repeat (3) begin
                        lfsr      = lfsr_next(lfsr);
                        delay_cnt = (delay_cnt << 1) | lfsr[0];
                    end
                end
            end else begin
                delay_cnt--;
            end
        end
    end

    task automatic abort_run(input string msg);
        $display("%s at %0t", msg, $time);
        $display("TB FAILED");
        $finish;
    endtask

    task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
                               input string msg);
        if (got !== exp) begin
            $display("mismatch at %0t: %s, got %h expected %h", $time, msg, got, exp);
            errors++;
        end
    endtask

    task automatic emit(input logic [31:0] word);
        mem[(load_ptr - 32'h8000_0000) >> 2] = word;
        load_ptr = load_ptr + 4;
    endtask

    // wait for one retire and compare it with the model
    task automatic retire_check();
        int          n;
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] immi;
        logic [31:0] wd;
        logic [31:0] npc;
        logic        we;
        logic        taken;
        n = 0;
        @(posedge clk);
        #1;
        while (!retire_valid) begin
            if (imem_req) begin
                check_equal(imem_addr, m_pc, "fetch address");
            end
            n++;
            if (n > TIMEOUT) begin
                abort_run("no instruction retired before the timeout");
            end
            @(posedge clk);
            #1;
        end
        ins   = mem_read(m_pc);
        a     = m_regs[ins[19:15]];
        b     = m_regs[ins[24:20]];
        immi  = {{20{ins[31]}}, ins[31:20]};
        npc   = m_pc + 4;
        we    = 1'b1;
        wd    = 32'h0;
        taken = 1'b0;
        case (ins[6:0])
            7'h33: wd = alu_ref(ins[14:12], ins[30], a, b);
            7'h13: wd = alu_ref(ins[14:12], ins[14:12] == 3'd5 && ins[30], a, immi);
            7'h37: wd = {ins[31:12], 12'b0};
            7'h17: wd = m_pc + {ins[31:12], 12'b0};
            7'h6f: begin
                wd  = m_pc + 4;
                npc = m_pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            7'h67: begin
                wd  = m_pc + 4;
                npc = (a + immi) & ~32'h1;
            end
            7'h63: begin
                we = 1'b0;
                case (ins[14:12])
                    3'd0:    taken = a == b;
                    3'd1:    taken = a != b;
                    3'd4:    taken = $signed(a) < $signed(b);
                    3'd5:    taken = $signed(a) >= $signed(b);
                    3'd6:    taken = a < b;
                    3'd7:    taken = a >= b;
                    default: taken = 1'b0;
                endcase
                if (taken) begin
                    npc = m_pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                end
            end
            default: we = 1'b0;
        endcase
        check_equal(retire_pc, m_pc, "retire pc");
        check_equal(retire_we, we, "retire write enable");
        if (we) begin
            check_equal(retire_rd, ins[11:7], "retire rd");
            check_equal(retire_wdata, wd, "retire write data");
            if (ins[11:7] != 0) begin
                m_regs[ins[11:7]] = wd;
            end
        end
        check_equal(retire_next_pc, npc, "retire next pc");
        m_pc = npc;
        retire_count++;
    endtask

    task automatic run_to(input logic [31:0] end_addr);
        int n;
        n = 0;
        while (m_pc != end_addr) begin
            retire_check();
            n++;
            if (n > 64) begin
                abort_run("program never reached its end address");
            end
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        tests++;
        if (errors == err_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - err_before);
        end
    endtask

    task automatic test_reset();
        int n;
        int e;
        e = errors;
        n = 0;
        while (reset) begin
            check_equal(imem_req, 1'b0, "imem_req during reset");
            check_equal(retire_valid, 1'b0, "retire_valid during reset");
            n++;
            if (n > TIMEOUT) begin
                abort_run("reset never released");
            end
            @(posedge clk);
            #1;
        end
        n = 0;
        while (!imem_req) begin
            n++;
            if (n > TIMEOUT) begin
                abort_run("no fetch request after reset");
            end
            @(posedge clk);
            #1;
        end
        check_equal(imem_addr, 32'h8000_0000, "first fetch address");
        retire_check();  // fill word at the reset pc
        report_test("reset", e);
    endtask

    // straight-line ALU program, every result in its own register
    task automatic emit_arith();
        emit(enc_i(-5, 0, 0, 1, 7'h13));      // addi x1, x0, -5
        emit(enc_i(7, 0, 0, 2, 7'h13));
        emit({20'h80000, 5'd3, 7'h37});       // lui
        emit({20'h00012, 5'd4, 7'h17});       // auipc
        emit(enc_r(0, 2, 1, 0, 5));
        emit(enc_r(32, 2, 1, 0, 6));          // sub
        emit(enc_r(0, 2, 1, 1, 7));
        emit(enc_r(0, 2, 1, 2, 8));
        emit(enc_r(0, 2, 1, 3, 9));
        emit(enc_r(0, 2, 1, 4, 10));
        emit(enc_r(0, 2, 1, 5, 11));
        emit(enc_r(32, 2, 1, 5, 12));         // sra
        emit(enc_r(0, 2, 1, 6, 13));
        emit(enc_r(0, 2, 1, 7, 14));
        emit(enc_i(-3, 1, 2, 15, 7'h13));     // slti
        emit(enc_i(1, 1, 3, 16, 7'h13));
        emit(enc_i(12'h7ff, 1, 4, 17, 7'h13));
        emit(enc_i(12'h0f0, 1, 6, 18, 7'h13));
        emit(enc_i(12'h0f0, 1, 7, 19, 7'h13));
        emit(enc_i(4, 1, 1, 20, 7'h13));
        emit(enc_i(3, 1, 5, 21, 7'h13));
        emit(enc_i(12'h403, 1, 5, 22, 7'h13)); // srai
    endtask

    task automatic test_arith();
        int e;
        e = errors;
        emit_arith();
        run_to(load_ptr);
        report_test("arithmetic", e);
    endtask

    task automatic test_x0();
        int e;
        e = errors;
        emit(enc_i(5, 2, 0, 0, 7'h13));       // addi x0, x2, 5
        emit(enc_r(0, 2, 0, 0, 23));          // add x23, x0, x2
        emit(enc_r(0, 0, 0, 6, 24));          // or x24, x0, x0
        run_to(load_ptr);
        report_test("x0", e);
    endtask

    task automatic test_branches();
        int e;
        int f3s [6]   = '{0, 1, 4, 5, 6, 7};
        int t_rs1 [6] = '{1, 1, 1, 2, 2, 1};
        int t_rs2 [6] = '{1, 2, 2, 1, 1, 2};
        int n_rs1 [6] = '{1, 1, 2, 1, 1, 2};
        int n_rs2 [6] = '{2, 1, 1, 2, 2, 1};
        e = errors;
        emit(enc_i(-5, 0, 0, 1, 7'h13));
        emit(enc_i(7, 0, 0, 2, 7'h13));
        for (int i = 0; i < 6; i++) begin
            emit(enc_b(8, t_rs2[i], t_rs1[i], f3s[i]));
            emit(enc_i(1, 30, 0, 30, 7'h13)); // skipped when taken
            emit(enc_b(8, n_rs2[i], n_rs1[i], f3s[i]));
            emit(enc_i(1, 30, 0, 30, 7'h13));
        end
        run_to(load_ptr);
        report_test("branches", e);
    endtask

    task automatic test_jumps();
        int e;
        e = errors;
        emit(enc_j(12, 5));                   // jal x5, +12
        emit(enc_i(1, 30, 0, 30, 7'h13));
        emit(enc_i(1, 30, 0, 30, 7'h13));
        emit({20'h0, 5'd6, 7'h17});           // auipc x6, 0
        emit(enc_i(13, 6, 0, 7, 7'h67));      // jalr x7, 13(x6), odd target
        emit(enc_i(1, 30, 0, 30, 7'h13));
        emit(enc_r(0, 7, 5, 0, 8));           // uses both links
        run_to(load_ptr);
        report_test("jumps", e);
    endtask

    // arithmetic again with LFSR fetch delays, one fetch per retire
    task automatic test_stalls();
        int e;
        e = errors;
        stall_mode   = 1'b1;
        fetch_count  = 0;
        retire_count = 0;
        emit_arith();
        run_to(load_ptr);
        check_equal(fetch_count, retire_count, "fetches versus retires");
        report_test("stalled arithmetic", e);
    endtask

    initial begin
        imem_valid   = 1'b0;
        imem_rdata   = 32'h0;
        stall_mode   = 1'b0;
        delay_cnt    = 0;
        lfsr         = 16'd71;
        errors       = 0;
        tests        = 0;
        fetch_count  = 0;
        retire_count = 0;
        m_pc         = 32'h8000_0000;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = fill_word(32'h8000_0000 + 32'(i) * 4);
        end
        for (int i = 0; i < 32; i++) begin
            m_regs[i] = 32'h0;
        end
        #1;
        test_reset();
        load_ptr = m_pc;
        test_arith();
        test_x0();
        test_branches();
        test_jumps();
        test_stalls();
        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/core_sva.sv
/* protocol checks on the core top level, bound into core_top
   only the fetch handshake and retire pulse are covered */
`timescale 1ns/1ps
`default_nettype none

module core_sva (
    input wire logic        clk,
    input wire logic        reset,
    input wire logic        imem_req,
    input wire logic [31:0] imem_addr,
    input wire logic        imem_valid,
    input wire logic        retire_valid
);

    // request and address held until memory answers
    req_held: assert property (@(posedge clk) disable iff (reset)
        imem_req && !imem_valid |=> imem_req && $stable(imem_addr))
        else $error("imem request dropped or address changed before imem_valid");

    one_cycle_retire: assert property (@(posedge clk) disable iff (reset)
        retire_valid |=> !retire_valid)
        else $error("retire_valid high in two consecutive cycles");

    quiet_in_reset: assert property (@(posedge clk)
        reset |-> !retire_valid && !imem_req)
        else $error("retire or fetch request seen during reset");

endmodule

bind core_top core_sva i_sva (.*);

`default_nettype wire

//--- verif/tb_clock_gen.sv
/* 100 ns clock, reset held high for the first 10 rising edges */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (10) @(posedge clk);
        #1 reset = 1'b0;  // released just after the edge, like other inputs
    end

endmodule

`default_nettype wire

//--- hdl/core_top.sv
/* RV32I integer core without loads, stores or CSRs
   memory must answer each held imem_req with exactly one imem_valid pulse */
`timescale 1ns/1ps
`default_nettype none

module core_top (
    input  logic                clk,
    input  logic                reset,
    output logic                imem_req,
    output core_pkg::word_t     imem_addr,
    input  logic                imem_valid,
    input  core_pkg::word_t     imem_rdata,
    output logic                retire_valid,
    output core_pkg::word_t     retire_pc,
    output logic                retire_we,
    output core_pkg::reg_addr_t retire_rd,
    output core_pkg::word_t     retire_wdata,
    output core_pkg::word_t     retire_next_pc
);

    logic                exec;
    core_pkg::word_t     inst;
    core_pkg::word_t     pc;
    core_pkg::word_t     next_pc;
    core_pkg::word_t     rs1_data;
    core_pkg::word_t     rs2_data;
    core_pkg::word_t     alu_result;
    logic                jump_en;
    core_pkg::word_t     jump_target;
    logic                gpr_we;
    core_pkg::reg_addr_t gpr_waddr;
    core_pkg::word_t     gpr_wdata;

    decode_if dec_bus ();

    fetch_unit i_fetch (
        .clk        (clk),
        .reset      (reset),
        .imem_req   (imem_req),
        .imem_addr  (imem_addr),
        .imem_valid (imem_valid),
        .imem_rdata (imem_rdata),
        .next_pc    (next_pc),
        .exec       (exec),
        .inst       (inst),
        .pc         (pc)
    );

    inst_decoder i_decoder (
        .inst (inst),
        .pc   (pc),
        .dec  (dec_bus.dec)
    );

    reg_file i_regs (
        .clk    (clk),
        .reset  (reset),
        .we     (gpr_we),
        .waddr  (gpr_waddr),
        .wdata  (gpr_wdata),
        .raddr1 (dec_bus.rs1),
        .raddr2 (dec_bus.rs2),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data)
    );

    exec_alu i_alu (
        .dec        (dec_bus.exe),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .alu_result (alu_result)
    );

    branch_unit i_branch (
        .dec         (dec_bus.exe),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .alu_result  (alu_result),
        .jump_en     (jump_en),
        .jump_target (jump_target)
    );

    writeback_unit i_wb (
        .exec           (exec),
        .dec            (dec_bus.wb),
        .alu_result     (alu_result),
        .jump_en        (jump_en),
        .jump_target    (jump_target),
        .next_pc        (next_pc),
        .gpr_we         (gpr_we),
        .gpr_waddr      (gpr_waddr),
        .gpr_wdata      (gpr_wdata),
        .retire_valid   (retire_valid),
        .retire_pc      (retire_pc),
        .retire_we      (retire_we),
        .retire_rd      (retire_rd),
        .retire_wdata   (retire_wdata),
        .retire_next_pc (retire_next_pc)
    );

endmodule

`default_nettype wire

//--- hdl/writeback_unit.sv
/* register write select, next pc and retire report
   outputs are only meaningful while exec is high */
`timescale 1ns/1ps
`default_nettype none

module writeback_unit (
    input  logic                exec,
    decode_if.wb                dec,
    input  core_pkg::word_t     alu_result,
    input  logic                jump_en,
    input  core_pkg::word_t     jump_target,
    output core_pkg::word_t     next_pc,
    output logic                gpr_we,
    output core_pkg::reg_addr_t gpr_waddr,
    output core_pkg::word_t     gpr_wdata,
    output logic                retire_valid,
    output core_pkg::word_t     retire_pc,
    output logic                retire_we,
    output core_pkg::reg_addr_t retire_rd,
    output core_pkg::word_t     retire_wdata,
    output core_pkg::word_t     retire_next_pc
);

    logic wr_intent;

    always_comb begin
        wr_intent = 1'b1;
        if (dec.inst_type == core_pkg::TYPE_J || dec.opcode == core_pkg::OPC_JALR) begin
            gpr_wdata = dec.snpc;  // link address
        end else begin
            gpr_wdata = alu_result;
            if (dec.inst_type == core_pkg::TYPE_B || dec.inst_type == core_pkg::TYPE_N) begin
                wr_intent = 1'b0;
            end
        end
    end

    assign next_pc   = jump_en ? jump_target : dec.snpc;
    assign gpr_we    = exec && wr_intent;  // rd == x0 filtered in the register file
    assign gpr_waddr = dec.rd;

    assign retire_valid   = exec;
    assign retire_pc      = dec.pc;
    assign retire_we      = gpr_we;
    assign retire_rd      = dec.rd;
    assign retire_wdata   = gpr_wdata;
    assign retire_next_pc = next_pc;

endmodule

`default_nettype wire

//--- hdl/branch_unit.sv
/* conditional branch compare and jump target
   reserved branch funct3 codes fall through as not taken */
`timescale 1ns/1ps
`default_nettype none

module branch_unit (
    decode_if.exe           dec,
    input  core_pkg::word_t rs1_data,
    input  core_pkg::word_t rs2_data,
    input  core_pkg::word_t alu_result,
    output logic            jump_en,
    output core_pkg::word_t jump_target
);

    logic            is_jalr;
    logic            taken;
    core_pkg::word_t pc_rel;

    assign is_jalr = (dec.opcode == core_pkg::OPC_JALR);
    assign pc_rel  = dec.pc + dec.imm;

    always_comb begin
        case (dec.funct3)
            3'b000:  taken = (rs1_data == rs2_data);                  // beq
            3'b001:  taken = (rs1_data != rs2_data);                  // bne
            3'b100:  taken = ($signed(rs1_data) < $signed(rs2_data));   // blt
            3'b101:  taken = ($signed(rs1_data) >= $signed(rs2_data));  // bge
            3'b110:  taken = (rs1_data < rs2_data);                   // bltu
            3'b111:  taken = (rs1_data >= rs2_data);                  // bgeu
            default: taken = 1'b0;
        endcase
    end

    assign jump_en = is_jalr || (dec.inst_type == core_pkg::TYPE_J) ||
                     (dec.inst_type == core_pkg::TYPE_B && taken);

    // jalr target is rs1 + imm from the ALU, lsb forced low
    assign jump_target = is_jalr ? {alu_result[31:1], 1'b0} : pc_rel;

endmodule

`default_nettype wire

//--- hdl/exec_alu.sv
/* operand select and integer ALU
   result for J and B classes is unused, the branch unit forms those targets */
`timescale 1ns/1ps
`default_nettype none

module exec_alu (
    decode_if.exe           dec,
    input  core_pkg::word_t rs1_data,
    input  core_pkg::word_t rs2_data,
    output core_pkg::word_t alu_result
);

    core_pkg::word_t op_a;
    core_pkg::word_t op_b;
    logic [4:0]      shamt;

    always_comb begin
        if (dec.opcode == core_pkg::OPC_LUI) begin
            op_a = '0;
        end else if (dec.opcode == core_pkg::OPC_AUIPC || dec.inst_type == core_pkg::TYPE_J ||
                     dec.inst_type == core_pkg::TYPE_B) begin
            op_a = dec.pc;
        end else begin
            op_a = rs1_data;
        end
    end

    assign op_b  = (dec.inst_type == core_pkg::TYPE_R) ? rs2_data : dec.imm;
    assign shamt = op_b[4:0];  // shift amount only

    always_comb begin
        case (dec.alu_op)
            core_pkg::ALU_SUB:  alu_result = op_a - op_b;
            core_pkg::ALU_SLL:  alu_result = op_a << shamt;
            core_pkg::ALU_SLT:  alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
            core_pkg::ALU_SLTU: alu_result = {31'b0, op_a < op_b};
            core_pkg::ALU_XOR:  alu_result = op_a ^ op_b;
            core_pkg::ALU_SRL:  alu_result = op_a >> shamt;
            core_pkg::ALU_SRA:  alu_result = $signed(op_a) >>> shamt;
            core_pkg::ALU_OR:   alu_result = op_a | op_b;
            core_pkg::ALU_AND:  alu_result = op_a & op_b;
            default:            alu_result = op_a + op_b;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/reg_file.sv
/* 32 x 32 register file, asynchronous reads, write on the clock edge
   x0 reads as zero and ignores writes */
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic                clk,
    input  logic                reset,
    input  logic                we,
    input  core_pkg::reg_addr_t waddr,
    input  core_pkg::word_t     wdata,
    input  core_pkg::reg_addr_t raddr1,
    input  core_pkg::reg_addr_t raddr2,
    output core_pkg::word_t     rdata1,
    output core_pkg::word_t     rdata2
);

    core_pkg::word_t regs [core_pkg::NUM_REGS];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < core_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

//--- hdl/inst_decoder.sv
/* purely combinational decode of the registered instruction
   unknown opcodes become TYPE_N and are never written back */
`timescale 1ns/1ps
`default_nettype none

module inst_decoder (
    input  core_pkg::word_t inst,
    input  core_pkg::word_t pc,
    decode_if.dec           dec
);

    logic [6:0] funct7;

    assign funct7     = inst[31:25];
    assign dec.pc     = pc;
    assign dec.snpc   = pc + 32'd4;
    assign dec.opcode = inst[6:0];
    assign dec.funct3 = inst[14:12];
    assign dec.rd     = inst[11:7];
    assign dec.rs1    = inst[19:15];
    assign dec.rs2    = inst[24:20];

    always_comb begin
        case (dec.opcode)
            core_pkg::OPC_OP:                      dec.inst_type = core_pkg::TYPE_R;
            core_pkg::OPC_OP_IMM, core_pkg::OPC_JALR: dec.inst_type = core_pkg::TYPE_I;
            core_pkg::OPC_LUI, core_pkg::OPC_AUIPC:  dec.inst_type = core_pkg::TYPE_U;
            core_pkg::OPC_JAL:                     dec.inst_type = core_pkg::TYPE_J;
            core_pkg::OPC_BRANCH:                  dec.inst_type = core_pkg::TYPE_B;
            default:                               dec.inst_type = core_pkg::TYPE_N;
        endcase
    end

    always_comb begin
        case (dec.inst_type)
            core_pkg::TYPE_I: dec.imm = {{20{inst[31]}}, inst[31:20]};
            core_pkg::TYPE_U: dec.imm = {inst[31:12], 12'b0};
            core_pkg::TYPE_B: begin
                dec.imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            core_pkg::TYPE_J: begin
                dec.imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            default: dec.imm = '0;
        endcase
    end

    // lui, auipc, jalr default to add
    always_comb begin
        dec.alu_op = core_pkg::ALU_ADD;
        if (dec.inst_type == core_pkg::TYPE_R || dec.opcode == core_pkg::OPC_OP_IMM) begin
            case (dec.funct3)
                3'b000: begin
                    if (dec.inst_type == core_pkg::TYPE_R && funct7[5]) begin
                        dec.alu_op = core_pkg::ALU_SUB;  // no subi
                    end
                end
                3'b001:  dec.alu_op = core_pkg::ALU_SLL;
                3'b010:  dec.alu_op = core_pkg::ALU_SLT;
                3'b011:  dec.alu_op = core_pkg::ALU_SLTU;
                3'b100:  dec.alu_op = core_pkg::ALU_XOR;
                3'b101:  dec.alu_op = funct7[5] ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
                3'b110:  dec.alu_op = core_pkg::ALU_OR;
                default: dec.alu_op = core_pkg::ALU_AND;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hdl/fetch_unit.sv
/* one instruction in flight; request held until the single imem_valid pulse
   no timeout, a memory that never answers stalls the core */
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
    input  logic            clk,
    input  logic            reset,
    output logic            imem_req,
    output core_pkg::word_t imem_addr,
    input  logic            imem_valid,
    input  core_pkg::word_t imem_rdata,
    input  core_pkg::word_t next_pc,
    output logic            exec,
    output core_pkg::word_t inst,
    output core_pkg::word_t pc
);

    core_pkg::fetch_state_t state;
    logic                   fetch_done;

    assign fetch_done = imem_req && imem_valid;  // valid ignored without a request
    assign exec       = (state == core_pkg::EXEC);
    assign imem_addr  = pc;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= core_pkg::FETCH;
            imem_req <= 1'b0;
            pc       <= core_pkg::RESET_PC;
        end else begin
            case (state)
                core_pkg::FETCH: begin
                    if (fetch_done) begin
                        state    <= core_pkg::EXEC;
                        imem_req <= 1'b0;
                    end else begin
                        imem_req <= 1'b1;  // first request right after reset
                    end
                end
                core_pkg::EXEC: begin
                    // retire and start the next fetch on the same edge
                    state    <= core_pkg::FETCH;
                    imem_req <= 1'b1;
                    pc       <= next_pc;
                end
                default: state <= core_pkg::FETCH;
            endcase
        end
    end

    // instruction register
    always_ff @(posedge clk) begin
        if (fetch_done) begin
            inst <= imem_rdata;
        end
    end

endmodule

`default_nettype wire

//--- hdl/decode_if.sv
/* decoded instruction bundle, driven only by the decoder
   contents are meaningful during the EXEC cycle */
`timescale 1ns/1ps
`default_nettype none

interface decode_if;

    core_pkg::word_t      pc;
    core_pkg::word_t      snpc;       // pc + 4
    core_pkg::opcode_t    opcode;
    core_pkg::funct3_t    funct3;
    core_pkg::reg_addr_t  rd;
    core_pkg::reg_addr_t  rs1;
    core_pkg::reg_addr_t  rs2;
    core_pkg::word_t      imm;        // already sign extended
    core_pkg::inst_type_t inst_type;
    core_pkg::alu_op_t    alu_op;

    modport dec (output pc, snpc, opcode, funct3, rd, rs1, rs2, imm, inst_type, alu_op);

    modport exe (input pc, opcode, funct3, imm, inst_type, alu_op);

    modport wb (input pc, snpc, opcode, rd, inst_type);

endinterface

`default_nettype wire

//--- hdl/core_pkg.sv
/* shared types and constants for the RV32I multicycle core
   only the integer subset is decoded, other opcodes retire as no-ops */
`default_nettype none

package core_pkg;

    localparam int XLEN     = 32;
    localparam int NUM_REGS = 32;

    typedef logic [XLEN-1:0]             word_t;
    typedef logic [$clog2(NUM_REGS)-1:0] reg_addr_t;
    typedef logic [2:0]                  funct3_t;
    typedef logic [6:0]                  opcode_t;

    localparam word_t RESET_PC = 32'h8000_0000;  // first fetch after reset

    // major opcodes kept by this core
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_BRANCH = 7'b1100011;

    typedef enum logic [2:0] {
        TYPE_R,
        TYPE_I,  // op-imm and jalr
        TYPE_U,
        TYPE_J,
        TYPE_B,
        TYPE_N   // anything not decoded
    } inst_type_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_t;

    typedef enum logic {
        FETCH,
        EXEC
    } fetch_state_t;

endpackage

`default_nettype wire
